/* common/evt_pkg.sv */
// event counter shared definitions

package evt_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // axi4-lite address and data widths
  parameter int unsigned AddrWidth = 8;
  parameter int unsigned DataWidth = 32;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  // byte offsets of the register file
  parameter logic [AddrWidth-1:0] RegCtrl      = 8'h00;
  parameter logic [AddrWidth-1:0] RegClear     = 8'h04;
  // count registers follow on word steps from here
  parameter logic [AddrWidth-1:0] RegCountBase = 8'h10;

  // axi response codes in use
  parameter logic [1:0] RespOkay   = 2'b00;
  parameter logic [1:0] RespSlverr = 2'b10;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  // one decoded register access per accepted request
  typedef enum logic [2:0] {
    OpNone,
    OpWrCtrl,
    OpWrClear,
    OpRdCtrl,
    OpRdClear,
    OpRdCount,
    OpWrBad,
    OpRdBad
  } reg_op_e;

  // request decoder states
  typedef enum logic {
    StIdle,
    StWaitResp
  } dec_state_e;

endpackage

/* source/flop_2sync.sv */
// two stage synchronizer
`timescale 1ns/1ps

module flop_2sync #(
  parameter int unsigned Width = 1
) (
  input  logic             clk_dst_i,
  input  logic             rst_dst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  // first stage may go metastable, second stage settles it
  logic [Width-1:0] meta_q;
  logic [Width-1:0] sync_q;

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  // only the second stage is safe to use downstream
  assign q_o = sync_q;

endmodule

/* source/pulse_sync.sv */
// source to destination pulse crossing
`timescale 1ns/1ps

module pulse_sync (
  // source domain
  input  logic clk_src_i,
  input  logic rst_src_ni,
  input  logic src_pulse_i,
  // destination domain
  input  logic clk_dst_i,
  input  logic rst_dst_ni,
  output logic dst_pulse_o
);

  ////////////////////////////////////////
  // source side toggle
  ////////////////////////////////////////

  // flips once per source pulse so the event survives as a level
  logic src_tgl_q;

  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      src_tgl_q <= 1'b0;
    end else if (src_pulse_i) begin
      src_tgl_q <= ~src_tgl_q;
    end
  end

  ////////////////////////////////////////
  // level crossing
  ////////////////////////////////////////

  logic dst_tgl;

  flop_2sync #(
    .Width(1)
  ) u_flop_2sync (
    .clk_dst_i (clk_dst_i),
    .rst_dst_ni(rst_dst_ni),
    .d_i       (src_tgl_q),
    .q_o       (dst_tgl)
  );

  ////////////////////////////////////////
  // edge back to pulse
  ////////////////////////////////////////

  // previous synchronized level
  logic dst_tgl_q;

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      dst_tgl_q <= 1'b0;
    end else begin
      dst_tgl_q <= dst_tgl;
    end
  end

  // any change of the level marks one event
  assign dst_pulse_o = dst_tgl ^ dst_tgl_q;

endmodule

/* axil/axil_decode.sv */
// axi4-lite request decoder
`timescale 1ns/1ps

module axil_decode #(
  parameter int unsigned NumEvents = 4
) (
  input  logic                             clk_dst_i,
  input  logic                             rst_dst_ni,
  // write address and data
  input  logic [evt_pkg::AddrWidth-1:0]    awaddr_i,
  input  logic                             awvalid_i,
  output logic                             awready_o,
  input  logic [evt_pkg::DataWidth-1:0]    wdata_i,
  input  logic                             wvalid_i,
  output logic                             wready_o,
  // read address
  input  logic [evt_pkg::AddrWidth-1:0]    araddr_i,
  input  logic                             arvalid_i,
  output logic                             arready_o,
  // response taken by the master
  input  logic                             resp_done_i,
  // decoded request
  output evt_pkg::reg_op_e                 op_o,
  output logic [2:0]                       idx_o,
  output logic [evt_pkg::DataWidth-1:0]    wdata_o
);

  evt_pkg::dec_state_e state_q, state_d;
  evt_pkg::reg_op_e    wr_op, rd_op;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  // offset into the count window, and its word number
  logic [evt_pkg::AddrWidth-1:0] cnt_off;
  logic [evt_pkg::AddrWidth-3:0] cnt_word;
  logic                          cnt_hit;

  assign cnt_off  = araddr_i - evt_pkg::RegCountBase;
  assign cnt_word = cnt_off[evt_pkg::AddrWidth-1:2];

  // word aligned, above the base and below the last event line
  assign cnt_hit = (araddr_i >= evt_pkg::RegCountBase) &&
                   (cnt_off[1:0] == 2'b00) &&
                   (cnt_word < NumEvents);

  // writes reach only ctrl and clear
  always_comb begin
    case (awaddr_i)
      evt_pkg::RegCtrl:  wr_op = evt_pkg::OpWrCtrl;
      evt_pkg::RegClear: wr_op = evt_pkg::OpWrClear;
      // count registers are read only, so they land here too
      default:           wr_op = evt_pkg::OpWrBad;
    endcase
  end

  // reads see the whole map
  always_comb begin
    if (araddr_i == evt_pkg::RegCtrl) begin
      rd_op = evt_pkg::OpRdCtrl;
    end else if (araddr_i == evt_pkg::RegClear) begin
      rd_op = evt_pkg::OpRdClear;
    end else if (cnt_hit) begin
      rd_op = evt_pkg::OpRdCount;
    end else begin
      rd_op = evt_pkg::OpRdBad;
    end
  end

  // index is only meaningful with OpRdCount
  assign idx_o   = cnt_word[2:0];
  assign wdata_o = wdata_i;

  ////////////////////////////////////////
  // handshake fsm
  ////////////////////////////////////////

  always_comb begin
    awready_o = 1'b0;
    wready_o  = 1'b0;
    arready_o = 1'b0;
    op_o      = evt_pkg::OpNone;
    state_d   = state_q;
    case (state_q)
      evt_pkg::StIdle: begin
        // address and data must arrive together, and writes go first
        if (awvalid_i && wvalid_i) begin
          awready_o = 1'b1;
          wready_o  = 1'b1;
          op_o      = wr_op;
          state_d   = evt_pkg::StWaitResp;
        end else if (arvalid_i) begin
          arready_o = 1'b1;
          op_o      = rd_op;
          state_d   = evt_pkg::StWaitResp;
        end
      end
      evt_pkg::StWaitResp: begin
        // block new requests until the response leaves
        if (resp_done_i) begin
          state_d = evt_pkg::StIdle;
        end
      end
      default: state_d = evt_pkg::StIdle;
    endcase
  end

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      state_q <= evt_pkg::StIdle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* axil/axil_result.sv */
// axi4-lite response holder
`timescale 1ns/1ps

module axil_result (
  input  logic                          clk_dst_i,
  input  logic                          rst_dst_ni,
  // executed request
  input  evt_pkg::reg_op_e              op_i,
  input  logic [evt_pkg::DataWidth-1:0] rdata_i,
  input  logic [1:0]                    resp_i,
  // write response channel
  output logic                          bvalid_o,
  output logic [1:0]                    bresp_o,
  input  logic                          bready_i,
  // read data channel
  output logic                          rvalid_o,
  output logic [evt_pkg::DataWidth-1:0] rdata_o,
  output logic [1:0]                    rresp_o,
  input  logic                          rready_i,
  // master took the pending response
  output logic                          resp_done_o
);

  logic is_wr;
  logic is_rd;

  // sort the opcode by channel
  always_comb begin
    is_wr = 1'b0;
    is_rd = 1'b0;
    case (op_i)
      evt_pkg::OpWrCtrl, evt_pkg::OpWrClear, evt_pkg::OpWrBad: is_wr = 1'b1;
      evt_pkg::OpRdCtrl, evt_pkg::OpRdClear,
      evt_pkg::OpRdCount, evt_pkg::OpRdBad:                    is_rd = 1'b1;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // valid flags
  ////////////////////////////////////////

  // set one cycle after the request edge, drop on acceptance
  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      if (is_wr) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (is_rd) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  // captured once per request, stable while valid
  always_ff @(posedge clk_dst_i) begin
    if (is_wr) begin
      bresp_o <= resp_i;
    end
    if (is_rd) begin
      rdata_o <= rdata_i;
      rresp_o <= resp_i;
    end
  end

  // lets the decoder take the next request
  assign resp_done_o = (bvalid_o && bready_i) || (rvalid_o && rready_i);

endmodule

/* counters/event_counters.sv */
// saturating event counter bank
`timescale 1ns/1ps

module event_counters #(
  parameter int unsigned NumEvents = 4,
  parameter int unsigned CntWidth  = 16
) (
  input  logic                          clk_dst_i,
  input  logic                          rst_dst_ni,
  // synchronized event pulses
  input  logic [NumEvents-1:0]          evt_dst_i,
  // decoded register access
  input  evt_pkg::reg_op_e              op_i,
  input  logic [2:0]                    idx_i,
  input  logic [evt_pkg::DataWidth-1:0] wdata_i,
  // read result for this cycle's opcode
  output logic [evt_pkg::DataWidth-1:0] rdata_o,
  output logic [1:0]                    resp_o
);

  logic [NumEvents-1:0] en_q;
  logic [CntWidth-1:0]  cnt_q [NumEvents];
  logic [NumEvents-1:0] clr;
  logic [NumEvents-1:0] inc;

  ////////////////////////////////////////
  // enable mask
  ////////////////////////////////////////

  // every line counts out of reset
  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      en_q <= '1;
    end else if (op_i == evt_pkg::OpWrCtrl) begin
      en_q <= wdata_i[NumEvents-1:0];
    end
  end

  ////////////////////////////////////////
  // counters
  ////////////////////////////////////////

  // clear pattern applies only with a clear write
  assign clr = (op_i == evt_pkg::OpWrClear) ? wdata_i[NumEvents-1:0] : '0;

  // count while enabled and not yet at all ones
  always_comb begin
    for (int i = 0; i < NumEvents; i++) begin
      inc[i] = evt_dst_i[i] && en_q[i] && !(&cnt_q[i]);
    end
  end

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      for (int i = 0; i < NumEvents; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumEvents; i++) begin
        // clear beats an increment in the same cycle
        if (clr[i]) begin
          cnt_q[i] <= '0;
        end else if (inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // read data and response
  ////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    resp_o  = evt_pkg::RespOkay;
    case (op_i)
      evt_pkg::OpRdCtrl: rdata_o[NumEvents-1:0] = en_q;
      evt_pkg::OpRdCount: begin
        // index already range checked by the decoder
        for (int i = 0; i < NumEvents; i++) begin
          if (idx_i == 3'(i)) begin
            rdata_o[CntWidth-1:0] = cnt_q[i];
          end
        end
      end
      evt_pkg::OpWrBad, evt_pkg::OpRdBad: resp_o = evt_pkg::RespSlverr;
      // clear reads as zero, writes return no data
      default: ;
    endcase
  end

endmodule

/* source/evt_cdc_top.sv */
// cross clock event counter top
`timescale 1ns/1ps

module evt_cdc_top #(
  parameter int unsigned NumEvents = 4,
  parameter int unsigned CntWidth  = 16
) (
  // source domain
  input  logic                              clk_src_i,
  input  logic                              rst_src_ni,
  input  logic [NumEvents-1:0]              evt_i,
  // destination domain
  input  logic                              clk_dst_i,
  input  logic                              rst_dst_ni,
  // axi4-lite slave
  input  logic [evt_pkg::AddrWidth-1:0]     s_awaddr_i,
  input  logic                              s_awvalid_i,
  output logic                              s_awready_o,
  input  logic [evt_pkg::DataWidth-1:0]     s_wdata_i,
  input  logic [evt_pkg::DataWidth/8-1:0]   s_wstrb_i,
  input  logic                              s_wvalid_i,
  output logic                              s_wready_o,
  output logic [1:0]                        s_bresp_o,
  output logic                              s_bvalid_o,
  input  logic                              s_bready_i,
  input  logic [evt_pkg::AddrWidth-1:0]     s_araddr_i,
  input  logic                              s_arvalid_i,
  output logic                              s_arready_o,
  output logic [evt_pkg::DataWidth-1:0]     s_rdata_o,
  output logic [1:0]                        s_rresp_o,
  output logic                              s_rvalid_o,
  input  logic                              s_rready_i
);

  // events in the destination domain
  logic [NumEvents-1:0]          evt_dst;
  // decoded request
  evt_pkg::reg_op_e              op;
  logic [2:0]                    idx;
  logic [evt_pkg::DataWidth-1:0] wdata;
  // execute result
  logic [evt_pkg::DataWidth-1:0] rdata;
  logic [1:0]                    resp;
  logic                          resp_done;

  ////////////////////////////////////////
  // event crossing
  ////////////////////////////////////////

  // one synchronizer per line
  for (genvar i = 0; i < NumEvents; i++) begin : g_sync
    pulse_sync u_pulse_sync (
      .clk_src_i  (clk_src_i),
      .rst_src_ni (rst_src_ni),
      .src_pulse_i(evt_i[i]),
      .clk_dst_i  (clk_dst_i),
      .rst_dst_ni (rst_dst_ni),
      .dst_pulse_o(evt_dst[i])
    );
  end

  ////////////////////////////////////////
  // register path
  ////////////////////////////////////////

  // decode stage, every write is a full word
  axil_decode #(
    .NumEvents(NumEvents)
  ) u_decode (
    .clk_dst_i  (clk_dst_i),
    .rst_dst_ni (rst_dst_ni),
    .awaddr_i   (s_awaddr_i),
    .awvalid_i  (s_awvalid_i),
    .awready_o  (s_awready_o),
    .wdata_i    (s_wdata_i),
    .wvalid_i   (s_wvalid_i),
    .wready_o   (s_wready_o),
    .araddr_i   (s_araddr_i),
    .arvalid_i  (s_arvalid_i),
    .arready_o  (s_arready_o),
    .resp_done_i(resp_done),
    .op_o       (op),
    .idx_o      (idx),
    .wdata_o    (wdata)
  );

  // execute stage
  event_counters #(
    .NumEvents(NumEvents),
    .CntWidth (CntWidth)
  ) u_counters (
    .clk_dst_i (clk_dst_i),
    .rst_dst_ni(rst_dst_ni),
    .evt_dst_i (evt_dst),
    .op_i      (op),
    .idx_i     (idx),
    .wdata_i   (wdata),
    .rdata_o   (rdata),
    .resp_o    (resp)
  );

  // result stage
  axil_result u_result (
    .clk_dst_i  (clk_dst_i),
    .rst_dst_ni (rst_dst_ni),
    .op_i       (op),
    .rdata_i    (rdata),
    .resp_i     (resp),
    .bvalid_o   (s_bvalid_o),
    .bresp_o    (s_bresp_o),
    .bready_i   (s_bready_i),
    .rvalid_o   (s_rvalid_o),
    .rdata_o    (s_rdata_o),
    .rresp_o    (s_rresp_o),
    .rready_i   (s_rready_i),
    .resp_done_o(resp_done)
  );

endmodule

/* verif/evt_cdc_properties.sv */
// event counter protocol checks
`timescale 1ns/1ps

module evt_cdc_properties #(
  parameter int unsigned NumEvents = 4,
  parameter int unsigned CntWidth  = 16
) (
  input logic                          clk_dst_i,
  input logic                          rst_dst_ni,
  input logic                          s_awready_o,
  input logic                          s_wready_o,
  input logic                          s_arready_o,
  input logic                          s_bvalid_o,
  input logic [1:0]                    s_bresp_o,
  input logic                          s_bready_i,
  input logic                          s_rvalid_o,
  input logic [evt_pkg::DataWidth-1:0] s_rdata_o,
  input logic [1:0]                    s_rresp_o,
  input logic                          s_rready_i,
  // decoded request and counter state
  input evt_pkg::reg_op_e              op_i,
  input logic [evt_pkg::DataWidth-1:0] wdata_i,
  input logic [CntWidth-1:0]           cnt_i [NumEvents]
);

  ////////////////////////////////////////
  // response channels
  ////////////////////////////////////////

  // write response waits for bready
  assert property (@(posedge clk_dst_i) disable iff (!rst_dst_ni)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
    else $error("write response dropped or changed before bready");

  // read data waits for rready
  assert property (@(posedge clk_dst_i) disable iff (!rst_dst_ni)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
    else $error("read response dropped or changed before rready");

  // one transaction at a time
  assert property (@(posedge clk_dst_i) disable iff (!rst_dst_ni)
    (s_bvalid_o || s_rvalid_o) |-> !(s_awready_o || s_wready_o || s_arready_o))
    else $error("request accepted while a response is pending");

  // quiet bus while held in reset
  assert property (@(posedge clk_dst_i)
    !rst_dst_ni |-> !(s_awready_o || s_wready_o || s_arready_o || s_bvalid_o || s_rvalid_o))
    else $error("ready or valid high during reset");

  ////////////////////////////////////////
  // counters
  ////////////////////////////////////////

  for (genvar i = 0; i < NumEvents; i++) begin : g_cnt
    // only a clear brings a count down
    assert property (@(posedge clk_dst_i) disable iff (!rst_dst_ni)
      !(op_i == evt_pkg::OpWrClear && wdata_i[i]) |=> cnt_i[i] >= $past(cnt_i[i]))
      else $error("counter %0d decreased without a clear", i);
  end

endmodule

bind evt_cdc_top evt_cdc_properties #(
  .NumEvents(NumEvents),
  .CntWidth (CntWidth)
) i_props (
  .clk_dst_i  (clk_dst_i),
  .rst_dst_ni (rst_dst_ni),
  .s_awready_o(s_awready_o),
  .s_wready_o (s_wready_o),
  .s_arready_o(s_arready_o),
  .s_bvalid_o (s_bvalid_o),
  .s_bresp_o  (s_bresp_o),
  .s_bready_i (s_bready_i),
  .s_rvalid_o (s_rvalid_o),
  .s_rdata_o  (s_rdata_o),
  .s_rresp_o  (s_rresp_o),
  .s_rready_i (s_rready_i),
  .op_i       (op),
  .wdata_i    (wdata),
  .cnt_i      (u_counters.cnt_q)
);

/* verif/tb_evt_cdc.sv */
// event counter testbench
`timescale 1ns/1ps

module tb_evt_cdc;

  localparam int unsigned NumEvents = 4;
  localparam int unsigned CntWidth  = 16;
  localparam int unsigned Timeout   = 200;
  localparam logic [31:0] Seed      = 32'h00a8_12ab;
  // all ones value of one counter
  localparam logic [31:0] CntMax    = (CntWidth == 32) ? '1 : ((32'd1 << CntWidth) - 1);

  logic                 clk_src = 1'b0;
  logic                 clk_dst = 1'b0;
  logic                 rst_src_n;
  logic                 rst_dst_n;
  logic [NumEvents-1:0] evt;
  logic [7:0]           awaddr;
  logic                 awvalid;
  logic                 awready;
  logic [31:0]          wdata;
  logic [3:0]           wstrb;
  logic                 wvalid;
  logic                 wready;
  logic [1:0]           bresp;
  logic                 bvalid;
  logic                 bready;
  logic [7:0]           araddr;
  logic                 arvalid;
  logic                 arready;
  logic [31:0]          rdata;
  logic [1:0]           rresp;
  logic                 rvalid;
  logic                 rready;

  // expected state of the counter bank
  logic [31:0]          model_cnt [NumEvents];
  logic [NumEvents-1:0] model_en;

  string       cur_test;
  int unsigned test_errors;
  int unsigned total_errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned checks;

  ////////////////////////////////////////
  // clocks and dut
  ////////////////////////////////////////

  always #2 clk_dst = ~clk_dst;
  // source runs slower and unrelated to the destination
  always #3 clk_src = ~clk_src;

  evt_cdc_top #(
    .NumEvents(NumEvents),
    .CntWidth (CntWidth)
  ) i_dut (
    .clk_src_i  (clk_src),
    .rst_src_ni (rst_src_n),
    .evt_i      (evt),
    .clk_dst_i  (clk_dst),
    .rst_dst_ni (rst_dst_n),
    .s_awaddr_i (awaddr),
    .s_awvalid_i(awvalid),
    .s_awready_o(awready),
    .s_wdata_i  (wdata),
    .s_wstrb_i  (wstrb),
    .s_wvalid_i (wvalid),
    .s_wready_o (wready),
    .s_bresp_o  (bresp),
    .s_bvalid_o (bvalid),
    .s_bready_i (bready),
    .s_araddr_i (araddr),
    .s_arvalid_i(arvalid),
    .s_arready_o(arready),
    .s_rdata_o  (rdata),
    .s_rresp_o  (rresp),
    .s_rvalid_o (rvalid),
    .s_rready_i (rready)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic give_up(input string what);
    $display("Timeout in test %s while waiting for %s", cur_test, what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act == exp) else begin
      test_errors++;
      $display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // full word write, master holds bready low for hold cycles
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input int unsigned hold, output logic [1:0] resp);
    int unsigned n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    // ready is combinational, so look at it away from the edge
    @(negedge clk_dst);
    while (!(awready && wready)) begin
      if (n == Timeout) give_up("awready and wready");
      n++;
      @(negedge clk_dst);
    end
    @(posedge clk_dst);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (hold) begin
      @(posedge clk_dst);
      #1;
    end
    bready = 1'b1;
    n = 0;
    @(negedge clk_dst);
    while (!bvalid) begin
      if (n == Timeout) give_up("bvalid");
      n++;
      @(negedge clk_dst);
    end
    resp = bresp;
    @(posedge clk_dst);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, input int unsigned hold,
                          output logic [31:0] data, output logic [1:0] resp);
    int unsigned n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    @(negedge clk_dst);
    while (!arready) begin
      if (n == Timeout) give_up("arready");
      n++;
      @(negedge clk_dst);
    end
    @(posedge clk_dst);
    #1;
    arvalid = 1'b0;
    repeat (hold) begin
      @(posedge clk_dst);
      #1;
    end
    rready = 1'b1;
    n = 0;
    @(negedge clk_dst);
    while (!rvalid) begin
      if (n == Timeout) give_up("rvalid");
      n++;
      @(negedge clk_dst);
    end
    data = rdata;
    resp = rresp;
    @(posedge clk_dst);
    #1;
    rready = 1'b0;
  endtask

  // one source cycle pulse, then the spacing the synchronizer needs
  task automatic send_pulse(input int unsigned line);
    @(posedge clk_src);
    #1;
    evt[line] = 1'b1;
    @(posedge clk_src);
    #1;
    evt[line] = 1'b0;
    repeat (4) @(posedge clk_src);
    if (model_en[line] && model_cnt[line] != CntMax) begin
      model_cnt[line] = model_cnt[line] + 1;
    end
  endtask

  task automatic send_burst(input int unsigned num);
    for (int unsigned k = 0; k < num; k++) begin
      send_pulse($urandom % NumEvents);
    end
    // settle so every pulse has crossed
    repeat (10) @(posedge clk_dst);
    #1;
  endtask

  task automatic check_counts(input int unsigned max_hold);
    logic [31:0] data;
    logic [1:0]  resp;
    for (int unsigned i = 0; i < NumEvents; i++) begin
      read_reg(8'(evt_pkg::RegCountBase + 4 * i), $urandom % (max_hold + 1), data, resp);
      check_value($sformatf("count %0d", i), model_cnt[i], data);
      check_value($sformatf("count %0d resp", i), 32'(evt_pkg::RespOkay), 32'(resp));
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin
    logic [31:0]          data;
    logic [1:0]           resp;
    logic [1:0]           rd_resp;
    logic [NumEvents-1:0] pattern;
    int unsigned          seed_ret;
    seed_ret  = $urandom(Seed);
    rst_src_n = 1'b0;
    rst_dst_n = 1'b0;
    evt       = '0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '1;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    model_en  = '1;
    for (int i = 0; i < NumEvents; i++) begin
      model_cnt[i] = '0;
    end
    repeat (10) @(posedge clk_dst);
    #1;
    rst_src_n = 1'b1;
    rst_dst_n = 1'b1;

    start_test("reset_values");
    read_reg(evt_pkg::RegCtrl, 0, data, resp);
    check_value("ctrl", 32'(model_en), data);
    check_value("ctrl resp", 32'(evt_pkg::RespOkay), 32'(resp));
    read_reg(evt_pkg::RegClear, 0, data, resp);
    check_value("clear", 32'd0, data);
    check_value("clear resp", 32'(evt_pkg::RespOkay), 32'(resp));
    check_counts(0);
    finish_test();

    start_test("count_events");
    send_burst(1 + $urandom % 20);
    check_counts(0);
    finish_test();

    start_test("enable_mask");
    pattern = NumEvents'($urandom);
    write_reg(evt_pkg::RegCtrl, 32'(pattern), 0, resp);
    check_value("ctrl write resp", 32'(evt_pkg::RespOkay), 32'(resp));
    model_en = pattern;
    read_reg(evt_pkg::RegCtrl, 0, data, resp);
    check_value("ctrl", 32'(model_en), data);
    send_burst(1 + $urandom % 20);
    check_counts(0);
    finish_test();

    start_test("clear");
    write_reg(evt_pkg::RegCtrl, 32'hffff_ffff, 0, resp);
    model_en = '1;
    send_burst(12);
    pattern = NumEvents'($urandom);
    write_reg(evt_pkg::RegClear, 32'(pattern), 0, resp);
    check_value("clear write resp", 32'(evt_pkg::RespOkay), 32'(resp));
    for (int i = 0; i < NumEvents; i++) begin
      if (pattern[i]) model_cnt[i] = '0;
    end
    check_counts(0);
    finish_test();

    start_test("errors");
    // nonzero counts so a stray clear would show
    send_burst(12);
    read_reg(8'h08, 0, data, resp);
    check_value("unmapped data", 32'd0, data);
    check_value("unmapped resp", 32'(evt_pkg::RespSlverr), 32'(resp));
    // data differs from the mask and hits some counters
    write_reg(evt_pkg::RegCountBase, 32'h0000_0005, 0, resp);
    check_value("count write resp", 32'(evt_pkg::RespSlverr), 32'(resp));
    read_reg(8'(evt_pkg::RegCountBase + 4 * NumEvents), 0, data, resp);
    check_value("bad index data", 32'd0, data);
    check_value("bad index resp", 32'(evt_pkg::RespSlverr), 32'(resp));
    read_reg(evt_pkg::RegCtrl, 0, data, resp);
    check_value("ctrl", 32'(model_en), data);
    check_counts(0);
    finish_test();

    start_test("back_pressure");
    send_burst(1 + $urandom % 20);
    check_counts(8);
    pattern = NumEvents'($urandom);
    model_en = pattern;
    // read waits behind the pending write response and sees the new mask
    fork
      write_reg(evt_pkg::RegCtrl, 32'(pattern), $urandom % 9, resp);
      read_reg(evt_pkg::RegCtrl, $urandom % 9, data, rd_resp);
    join
    check_value("ctrl write resp", 32'(evt_pkg::RespOkay), 32'(resp));
    check_value("ctrl", 32'(model_en), data);
    check_value("ctrl read resp", 32'(evt_pkg::RespOkay), 32'(rd_resp));
    send_burst(1 + $urandom % 20);
    check_counts(8);
    pattern = NumEvents'($urandom);
    write_reg(evt_pkg::RegClear, 32'(pattern), $urandom % 9, resp);
    check_value("clear write resp", 32'(evt_pkg::RespOkay), 32'(resp));
    for (int i = 0; i < NumEvents; i++) begin
      if (pattern[i]) model_cnt[i] = '0;
    end
    check_counts(8);
    finish_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
common/evt_pkg.sv
source/flop_2sync.sv
source/pulse_sync.sv
axil/axil_decode.sv
axil/axil_result.sv
counters/event_counters.sv
source/evt_cdc_top.sv
verif/evt_cdc_properties.sv
verif/tb_evt_cdc.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_evt_cdc -f list.f -o sim_evt_cdc

# the simulation may stop early on an assertion, the search below decides
out=$(./obj_dir/sim_evt_cdc 2>&1) || true
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"
